// File: verilog/decimPkg.sv
package decimPkg;

    // Frame and window geometry
    localparam int DSR      = 8;
    localparam int TAPS     = 24;
    localparam int LUT_SIZE = 4;

    // Fixed-point widths
    localparam int COEF_WIDTH  = 10;
    localparam int AHEAD_WIDTH = 16;
    localparam int BACK_WIDTH  = 18;
    localparam int OUT_WIDTH   = 14;

    // Lookback recursion scaling
    localparam int LEAK_SHIFT = 3;
    localparam int BACK_GAIN  = 4;
    localparam int BACK_SCALE = 2;

    // Frame in to result out, in clkDS cycles
    localparam int LATENCY = 4;

    // Lookahead FIR taps, index 0 weights the newest bit
    localparam logic signed [COEF_WIDTH-1:0] COEFS [TAPS] = '{
        10'sd40,  10'sd90,  10'sd150, 10'sd220, 10'sd290, 10'sd360,
        10'sd400, 10'sd450, 10'sd490, 10'sd505, 10'sd510, 10'sd511,
        10'sd511, 10'sd510, 10'sd505, 10'sd490, 10'sd450, 10'sd400,
        10'sd360, 10'sd290, 10'sd220, 10'sd150, 10'sd90,  10'sd40
    };

    typedef struct packed {
        logic [DSR-1:0] data;
        logic           valid;
    } frameT;

    typedef struct packed {
        logic [OUT_WIDTH-1:0] sample;
        logic                 valid;
    } resultT;

    typedef enum logic {
        opAdd,
        opSub
    } combineOpT;

    typedef enum logic {
        warmFill,
        warmRun
    } warmStateT;

endpackage

// File: verilog/frameShifter.sv
`timescale 1ns/1ns

module frameShifter import decimPkg::*; (
    input  logic            clkDS,
    input  logic            arstN,
    input  frameT           frameIn,
    output logic [TAPS-1:0] window,
    output frameT           newFrame
);

    logic [DSR-1:0] reversed;

    // Frame MSB is the newest bit, so it lands at window index 0
    assign reversed = {<<{frameIn.data}};

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            window <= '0;
        end else if (frameIn.valid) begin
            // Older frames move toward the top of the window
            window <= {window[TAPS-DSR-1:0], reversed};
        end
    end

    // Copy of the accepted frame for the recursion, valid bit included
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            newFrame <= '0;
        end else begin
            newFrame <= frameIn;
        end
    end

endmodule

// File: verilog/lutDotProduct.sv
`timescale 1ns/1ns

module lutDotProduct import decimPkg::*; #(
    parameter int LUT_SIZE = decimPkg::LUT_SIZE
) (
    input  logic                          clkDS,
    input  logic                          arstN,
    input  logic [TAPS-1:0]               window,
    output logic signed [AHEAD_WIDTH-1:0] ahead
);

    localparam int NUM_GROUPS = (TAPS + LUT_SIZE - 1) / LUT_SIZE;
    localparam int ENTRIES    = 2 ** LUT_SIZE;
    localparam int TREE_WIDTH = AHEAD_WIDTH + $clog2(NUM_GROUPS);

    localparam logic signed [TREE_WIDTH-1:0] AHEAD_MAX = 2 ** (AHEAD_WIDTH - 1) - 1;
    localparam logic signed [TREE_WIDTH-1:0] AHEAD_MIN = -(2 ** (AHEAD_WIDTH - 1));

    typedef logic signed [AHEAD_WIDTH-1:0] tableT [ENTRIES];

    // Every signed partial sum of one group, set bit is +coef, clear bit is -coef
    function automatic tableT buildTable(input int group);
        tableT lut;
        int    tap;
        for (int e = 0; e < ENTRIES; e++) begin
            lut[e] = '0;
            for (int j = 0; j < LUT_SIZE; j++) begin
                tap = group * LUT_SIZE + j;
                if (tap < TAPS) begin
                    lut[e] = e[j] ? lut[e] + COEFS[tap] : lut[e] - COEFS[tap];
                end
            end
        end
        return lut;
    endfunction

    logic [NUM_GROUPS*LUT_SIZE-1:0] padded;
    logic signed [AHEAD_WIDTH-1:0]  groupSum [NUM_GROUPS];
    logic signed [TREE_WIDTH-1:0]   treeSum;

    // Spare bits of a short last group select taps with no coefficient
    assign padded = (NUM_GROUPS * LUT_SIZE)'(window);

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : genGroup
        localparam tableT LUT = buildTable(g);

        always_ff @(posedge clkDS or negedge arstN) begin
            if (!arstN) begin
                groupSum[g] <= '0;
            end else begin
                groupSum[g] <= LUT[padded[g*LUT_SIZE +: LUT_SIZE]];
            end
        end
    end

    always_comb begin
        treeSum = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            treeSum = treeSum + TREE_WIDTH'(groupSum[g]);
        end
    end

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            ahead <= '0;
        end else begin
            ahead <= treeSum[AHEAD_WIDTH-1:0];
        end
    end

    // Coefficient table must not overflow the lookahead width
    aheadRange: assert property (@(posedge clkDS) disable iff (!arstN)
        treeSum >= AHEAD_MIN && treeSum <= AHEAD_MAX);

endmodule

// File: verilog/lookbackRecursion.sv
`timescale 1ns/1ns

module lookbackRecursion import decimPkg::*; (
    input  logic                         clkDS,
    input  logic                         arstN,
    input  frameT                        newFrame,
    output logic signed [BACK_WIDTH-1:0] back
);

    localparam logic signed [BACK_WIDTH-1:0] BACK_MIN = {1'b1, {(BACK_WIDTH - 1){1'b0}}};

    logic [$clog2(DSR+1)-1:0]     ones;
    logic signed [BACK_WIDTH-1:0] frameSum;
    logic signed [BACK_WIDTH-1:0] state;

    always_comb begin
        ones = '0;
        for (int i = 0; i < DSR; i++) begin
            ones = ones + newFrame.data[i];
        end
    end

    // Bipolar bit sum, ones minus zeros
    assign frameSum = $signed(BACK_WIDTH'(ones) << 1) - BACK_WIDTH'(DSR);

    // Leaky integrator, advances only on accepted frames
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            state <= '0;
        end else if (newFrame.valid) begin
            state <= state - (state >>> LEAK_SHIFT) + (frameSum <<< BACK_GAIN);
        end
    end

    // One extra stage to meet the lookahead tree output
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            back <= '0;
        end else begin
            back <= state;
        end
    end

    stateFloor: assert property (@(posedge clkDS) disable iff (!arstN)
        newFrame.valid |=> state != BACK_MIN);

endmodule

// File: verilog/resultCombiner.sv
`timescale 1ns/1ns

module resultCombiner import decimPkg::*; (
    input  logic                          clkDS,
    input  logic                          arstN,
    input  combineOpT                     op,
    input  logic signed [AHEAD_WIDTH-1:0] ahead,
    input  logic signed [BACK_WIDTH-1:0]  back,
    output logic [OUT_WIDTH-1:0]          sample
);

    localparam int SUM_WIDTH = (AHEAD_WIDTH > BACK_WIDTH ? AHEAD_WIDTH : BACK_WIDTH) + 1;

    localparam logic signed [SUM_WIDTH-1:0] SAT_MAX = 2 ** (OUT_WIDTH - 1) - 1;
    localparam logic signed [SUM_WIDTH-1:0] SAT_MIN = -(2 ** (OUT_WIDTH - 1));

    logic signed [BACK_WIDTH-1:0] scaledBack;
    logic signed [SUM_WIDTH-1:0]  sum;
    logic signed [OUT_WIDTH-1:0]  saturated;

    assign scaledBack = back >>> BACK_SCALE;

    always_comb begin
        unique case (op)
            opAdd: sum = SUM_WIDTH'(ahead) + SUM_WIDTH'(scaledBack);
            opSub: sum = SUM_WIDTH'(ahead) - SUM_WIDTH'(scaledBack);
        endcase
    end

    // Clamp to the signed output range
    always_comb begin
        if (sum > SAT_MAX) begin
            saturated = SAT_MAX[OUT_WIDTH-1:0];
        end else if (sum < SAT_MIN) begin
            saturated = SAT_MIN[OUT_WIDTH-1:0];
        end else begin
            saturated = sum[OUT_WIDTH-1:0];
        end
    end

    // Offset binary, MSB flipped
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            sample <= '0;
        end else begin
            sample <= {~saturated[OUT_WIDTH-1], saturated[OUT_WIDTH-2:0]};
        end
    end

endmodule

// File: verilog/flowControl.sv
`timescale 1ns/1ns

module flowControl import decimPkg::*; #(
    parameter int OUT_CREDITS = 4
) (
    input  logic        clkDS,
    input  logic        arstN,
    input  logic        frameValid,
    input  logic        creditReturn,
    output logic        outValid,
    output logic        overrun,
    output logic [15:0] dropCount
);

    localparam int WARM_FRAMES  = TAPS / DSR;
    localparam int FILL_WIDTH   = $clog2(WARM_FRAMES + 1);
    // One spare code so an excess return stays visible
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 2);

    warmStateT                warmState;
    logic [FILL_WIDTH-1:0]    fillCount;
    logic                     frameCounts;
    logic [LATENCY-2:0]       validPipe;
    logic [CREDIT_WIDTH-1:0]  creditCount;
    logic                     ready;
    logic                     present;
    logic                     drop;

    // The frame that fills the window is the first to produce a result
    assign frameCounts = frameValid &&
        (warmState == warmRun || fillCount == FILL_WIDTH'(WARM_FRAMES - 1));

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            warmState <= warmFill;
            fillCount <= '0;
        end else if (warmState == warmFill && frameValid) begin
            fillCount <= fillCount + 1'b1;
            if (fillCount == FILL_WIDTH'(WARM_FRAMES - 1)) begin
                warmState <= warmRun;
            end
        end
    end

    // Last latency stage is the outValid register itself
    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[LATENCY-3:0], frameCounts};
        end
    end

    assign ready   = validPipe[LATENCY-2];
    assign present = ready && creditCount != '0;
    assign drop    = ready && creditCount == '0;

    always_ff @(posedge clkDS or negedge arstN) begin
        if (!arstN) begin
            creditCount <= CREDIT_WIDTH'(OUT_CREDITS);
            outValid    <= 1'b0;
            overrun     <= 1'b0;
            dropCount   <= '0;
        end else begin
            creditCount <= creditCount - CREDIT_WIDTH'(present) + CREDIT_WIDTH'(creditReturn);
            outValid    <= present;
            if (drop) begin
                overrun   <= 1'b1;
                dropCount <= dropCount + 16'd1;
            end
        end
    end

    creditCeiling: assert property (@(posedge clkDS) disable iff (!arstN)
        creditCount <= CREDIT_WIDTH'(OUT_CREDITS));

endmodule

// File: verilog/hybridDecimator.sv
`timescale 1ns/1ns

module hybridDecimator import decimPkg::*; #(
    parameter int OUT_CREDITS = 4,
    parameter int LUT_SIZE    = decimPkg::LUT_SIZE
) (
    input  logic        clkDS,
    input  logic        arstN,
    input  frameT       frameIn,
    input  logic        creditReturn,
    output resultT      resultOut,
    output logic        overrun,
    output logic [15:0] dropCount
);

    logic [TAPS-1:0]               window;
    frameT                         newFrame;
    logic signed [AHEAD_WIDTH-1:0] ahead;
    logic signed [BACK_WIDTH-1:0]  back;

    frameShifter shifter (
        .clkDS    (clkDS),
        .arstN    (arstN),
        .frameIn  (frameIn),
        .window   (window),
        .newFrame (newFrame)
    );

    // Lookahead FIR over the newest TAPS bits
    lutDotProduct #(
        .LUT_SIZE (LUT_SIZE)
    ) lookahead (
        .clkDS  (clkDS),
        .arstN  (arstN),
        .window (window),
        .ahead  (ahead)
    );

    lookbackRecursion lookback (
        .clkDS    (clkDS),
        .arstN    (arstN),
        .newFrame (newFrame),
        .back     (back)
    );

    resultCombiner combiner (
        .clkDS  (clkDS),
        .arstN  (arstN),
        .op     (opAdd),
        .ahead  (ahead),
        .back   (back),
        .sample (resultOut.sample)
    );

    flowControl #(
        .OUT_CREDITS (OUT_CREDITS)
    ) flow (
        .clkDS        (clkDS),
        .arstN        (arstN),
        .frameValid   (frameIn.valid),
        .creditReturn (creditReturn),
        .outValid     (resultOut.valid),
        .overrun      (overrun),
        .dropCount    (dropCount)
    );

endmodule

// File: bench/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clkDS,
    output logic arstN
);

    initial begin
        clkDS = 1'b0;
        forever #HALF_PERIOD clkDS = ~clkDS;
    end

    // Release lines up with the stimulus offset
    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clkDS);
        #1 arstN = 1'b1;
    end

endmodule

// File: bench/decimBench.sv
`timescale 1ns/1ns

module decimBench import decimPkg::*; ();

    localparam int OUT_CREDITS   = 4;
    localparam int WARM_FRAMES   = 20;
    localparam int DC_FRAMES     = 40;
    localparam int RANDOM_FRAMES = 200;
    localparam int BURST_FRAMES  = 10;
    localparam int TOTAL_FRAMES  = WARM_FRAMES + 2 * DC_FRAMES + RANDOM_FRAMES + 2 * BURST_FRAMES;
    localparam int CYCLE_LIMIT   = 2 * TOTAL_FRAMES + 200;

    logic        clkDS;
    logic        arstN;
    frameT       frameIn;
    logic        creditReturn;
    resultT      resultOut;
    logic        overrun;
    logic [15:0] dropCount;

    logic [31:0]          lfsr = 32'hd7e9_e4db;
    int                   cycle;
    int                   errors;
    int                   checks;
    int                   seen;
    int                   owed;
    int                   manualCredits;
    bit                   autoCredit;
    logic [OUT_WIDTH-1:0] lastSample;

    // Reference model state
    logic [TAPS-1:0]      modelWindow;
    int                   modelBack;
    int                   modelFrames;
    logic [OUT_WIDTH-1:0] expQ [$];
    int                   cycQ [$];

    clockGen clocks (
        .clkDS (clkDS),
        .arstN (arstN)
    );

    hybridDecimator #(
        .OUT_CREDITS (OUT_CREDITS),
        .LUT_SIZE    (LUT_SIZE)
    ) dut (
        .clkDS        (clkDS),
        .arstN        (arstN),
        .frameIn      (frameIn),
        .creditReturn (creditReturn),
        .resultOut    (resultOut),
        .overrun      (overrun),
        .dropCount    (dropCount)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic randBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) begin
            lfsr = lfsr ^ 32'hA300_0000;
        end
        return outBit;
    endfunction

    function automatic logic [DSR-1:0] randFrame();
        logic [DSR-1:0] data;
        for (int b = 0; b < DSR; b++) begin
            data[b] = randBit();
        end
        return data;
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // Sign-weighted FIR plus leaky frame recursion
    task automatic modelFrame(input logic [DSR-1:0] data);
        int ahead;
        int ones;
        int coef;
        int total;
        ones = 0;
        for (int b = 0; b < DSR; b++) begin
            modelWindow = {modelWindow[TAPS-2:0], data[b]};
            ones += data[b];
        end
        ahead = 0;
        for (int i = 0; i < TAPS; i++) begin
            coef = COEFS[i];
            ahead += modelWindow[i] ? coef : -coef;
        end
        modelBack = modelBack - (modelBack >>> LEAK_SHIFT) + ((2 * ones - DSR) <<< BACK_GAIN);
        total = ahead + (modelBack >>> BACK_SCALE);
        if (total > 2 ** (OUT_WIDTH - 1) - 1) begin
            total = 2 ** (OUT_WIDTH - 1) - 1;
        end else if (total < -(2 ** (OUT_WIDTH - 1))) begin
            total = -(2 ** (OUT_WIDTH - 1));
        end
        modelFrames++;
        // Window is full from the third frame on
        if (modelFrames >= TAPS / DSR) begin
            expQ.push_back(OUT_WIDTH'(total) ^ {1'b1, {(OUT_WIDTH - 1){1'b0}}});
            cycQ.push_back(cycle + LATENCY);
        end
    endtask

    task automatic drive(input logic [DSR-1:0] data, input logic valid);
        @(posedge clkDS);
        #1;
        frameIn.data  = data;
        frameIn.valid = valid;
        if (valid) begin
            modelFrame(data);
        end
    endtask

    // Wait for outstanding results and credits to settle
    task automatic drain();
        drive('0, 1'b0);
        while (expQ.size() != 0) @(negedge clkDS);
        while (owed != 0) @(negedge clkDS);
        repeat (2) @(posedge clkDS);
    endtask

    task automatic checkIdle();
        compare("resultOut.valid", 0, resultOut.valid);
        compare("overrun", 0, overrun);
        compare("dropCount", 0, dropCount);
    endtask

    task automatic resetTest();
        while (!arstN) begin
            @(negedge clkDS);
            checkIdle();
        end
        @(negedge clkDS);
        checkIdle();
    endtask

    task automatic warmupTest();
        repeat (WARM_FRAMES) drive(randFrame(), 1'b1);
        drain();
    endtask

    task automatic dcTest();
        repeat (DC_FRAMES) drive('1, 1'b1);
        drain();
        compare("resultOut.sample", {OUT_WIDTH{1'b1}}, lastSample);
        repeat (DC_FRAMES) drive('0, 1'b1);
        drain();
        compare("resultOut.sample", 0, lastSample);
    endtask

    task automatic randomTest();
        logic gapA;
        logic gapB;
        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            gapA = randBit();
            gapB = randBit();
            if (gapA && gapB) begin
                drive('0, 1'b0);
            end
            drive(randFrame(), 1'b1);
        end
        drain();
    endtask

    task automatic creditTest();
        int dropBase;
        int seenBase;
        int lastCycle;
        autoCredit = 1'b0;
        dropBase   = dropCount;
        seenBase   = seen;
        repeat (BURST_FRAMES) drive(randFrame(), 1'b1);
        drive('0, 1'b0);
        lastCycle = cycQ[$];
        while (cycle <= lastCycle) @(negedge clkDS);
        compare("presented results", OUT_CREDITS, seen - seenBase);
        compare("dropCount", dropBase + BURST_FRAMES - OUT_CREDITS, dropCount);
        compare("overrun", 1, overrun);
        compare("dropped entries", BURST_FRAMES - OUT_CREDITS, expQ.size());
        expQ.delete();
        cycQ.delete();
        manualCredits = OUT_CREDITS;
        while (manualCredits != 0) @(negedge clkDS);
        repeat (2) @(posedge clkDS);
        autoCredit = 1'b1;
        repeat (BURST_FRAMES) drive(randFrame(), 1'b1);
        drain();
    endtask

    // Result checker, also owes a credit per result
    always @(negedge clkDS) begin
        if (arstN && resultOut.valid) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("Result presented at %0t with no result expected", $time);
            end else begin
                compare("resultOut.sample", expQ.pop_front(), resultOut.sample);
                compare("result cycle", cycQ.pop_front(), cycle);
            end
            lastSample = resultOut.sample;
            seen++;
            if (autoCredit) begin
                owed++;
            end
        end
    end

    always @(posedge clkDS) begin
        #1;
        if (owed > 0) begin
            owed--;
            creditReturn = 1'b1;
        end else if (manualCredits > 0) begin
            manualCredits--;
            creditReturn = 1'b1;
        end else begin
            creditReturn = 1'b0;
        end
    end

    always @(posedge clkDS) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        frameIn       = '0;
        creditReturn  = 1'b0;
        autoCredit    = 1'b1;
        modelWindow   = '0;
        modelBack     = 0;
        modelFrames   = 0;
        manualCredits = 0;
        resetTest();
        warmupTest();
        dcTest();
        randomTest();
        creditTest();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/decimPkg.sv
verilog/frameShifter.sv
verilog/lutDotProduct.sv
verilog/lookbackRecursion.sv
verilog/resultCombiner.sv
verilog/flowControl.sv
verilog/hybridDecimator.sv
bench/clockGen.sv
bench/decimBench.sv
